//--- hw/gsm_pkg.sv
`default_nettype none

package gsm_pkg;

	// ------------------------------------------------------------------------
	// tile geometry
	// ------------------------------------------------------------------------

	// ingress links, egress links and cycles per cell slot are all the same
	localparam int N_PORTS = 4;

	localparam int DWIDTH = 128;   // one 16 byte cell

	// ------------------------------------------------------------------------
	// header cell fields
	// ------------------------------------------------------------------------

	// packet length in cells, header cell included
	localparam int LEN_LOC = 24;
	localparam int LEN_W   = 3;    // 1 to 7 cells

	// destination field, its low N_PORTS bits are the egress multicast mask
	localparam int DEST_LOC = 32;

	// ------------------------------------------------------------------------
	// types
	// ------------------------------------------------------------------------

	typedef logic [DWIDTH-1:0] cell_t;        // one cell on the data path
	typedef logic [N_PORTS-1:0] port_mask_t;  // one bit per egress link

	// per ingress packet state kept by the malloc
	typedef enum logic [1:0] {
		ST_IDLE,     // waiting for a header cell
		ST_ACCEPT,   // cells of an accepted packet get buffer space
		ST_DROP      // rest of a refused packet is thrown away
	} malloc_state_e;

endpackage

`default_nettype wire

//--- hw/cell_slot_mux.sv
`timescale 1ns/10ps
`default_nettype none

module cell_slot_mux #(
	parameter int AW = 5   // cell address width
) (
	input  wire                        clk_320M,
	input  wire                        i_rst,
	input  wire gsm_pkg::cell_t        i_ingress_data [gsm_pkg::N_PORTS],
	input  wire gsm_pkg::port_mask_t   i_req_wr,
	input  wire [AW-1:0]               i_req_addr [gsm_pkg::N_PORTS],
	input  wire gsm_pkg::port_mask_t   i_req_mask [gsm_pkg::N_PORTS],
	output logic                       o_cell_slot,
	output logic                       o_common_wr,
	output logic [AW-1:0]              o_common_addr,
	output gsm_pkg::port_mask_t        o_common_mask,
	output gsm_pkg::cell_t             o_common_data
);
	import gsm_pkg::*;

	logic [1:0]   phase;             // position inside the four cycle slot
	port_mask_t   sel;               // one hot, port p owns the bus in phase p+1
	cell_t        cell_q [N_PORTS];  // ingress cells of the current slot

	// ------------------------------------------------------------------------
	// slot timing
	// ------------------------------------------------------------------------

	// reset parks the counter one cycle before a slot boundary
	always_ff @(posedge clk_320M) begin
		if (i_rst) begin
			phase <= 2'(N_PORTS - 1);
			sel   <= port_mask_t'(1) << (N_PORTS - 2);   // lines up with phase 3
		end else begin
			phase <= phase + 2'd1;
			sel   <= {sel[N_PORTS-2:0], sel[N_PORTS-1]};   // rotate toward higher ports
		end
	end

	assign o_cell_slot = (phase == 2'd0);   // sampling edge closes this cycle

	// all four links are captured together on the slot edge
	always_ff @(posedge clk_320M) begin
		if (o_cell_slot) begin
			for (int p = 0; p < N_PORTS; p++)
				cell_q[p] <= i_ingress_data[p];
		end
	end

	// ------------------------------------------------------------------------
	// common write bus
	// ------------------------------------------------------------------------

	// requests come straight from the mallocs which hold them for the slot
	always_comb begin
		o_common_wr   = 1'b0;
		o_common_addr = '0;
		o_common_mask = '0;
		o_common_data = '0;
		for (int p = 0; p < N_PORTS; p++) begin
			if (sel[p]) begin
				o_common_wr   = i_req_wr[p];
				o_common_addr = i_req_addr[p];
				o_common_mask = i_req_mask[p];
				o_common_data = cell_q[p];
			end
		end
	end

	// select stays one hot and in step with the phase counter
	assert property (@(posedge clk_320M) disable iff (i_rst)
		$onehot(sel) && sel[phase - 2'd1]);

endmodule

`default_nettype wire

//--- hw/hw_malloc.sv
`timescale 1ns/10ps
`default_nettype none

module hw_malloc #(
	parameter int CELLS_PER_PORT = 8,
	parameter int PORT_IDX       = 0,   // selects this link's address block
	localparam int AW = $clog2(gsm_pkg::N_PORTS * CELLS_PER_PORT)
) (
	input  wire                         clk_320M,
	input  wire                         i_rst,
	input  wire                         i_slot,       // slot strobe
	input  wire                         i_valid,
	input  wire                         i_header,
	input  wire [gsm_pkg::LEN_W-1:0]    i_pkt_len,    // only meaningful on a header
	input  wire gsm_pkg::port_mask_t    i_dest_mask,
	input  wire [CELLS_PER_PORT-1:0]    i_free,       // cells released by the buffer
	output logic                        o_wr,
	output logic [AW-1:0]               o_addr,
	output gsm_pkg::port_mask_t         o_mask
);
	import gsm_pkg::*;

	localparam int LW = $clog2(CELLS_PER_PORT);       // local cell index
	localparam int FW = $clog2(CELLS_PER_PORT + 1);   // free count
	localparam logic [AW-1:0] BASE = AW'(PORT_IDX * CELLS_PER_PORT);

	logic [CELLS_PER_PORT-1:0]  free_map;    // 1 = cell available
	logic [FW-1:0]              free_cnt;
	logic [LW-1:0]              low_idx;     // lowest free cell
	logic                       hdr_ok;      // header passes admission
	logic                       alloc;
	logic [CELLS_PER_PORT-1:0]  alloc_vec;
	logic [LEN_W-1:0]           rem;         // cells still to come after this one
	malloc_state_e              state;

	// ------------------------------------------------------------------------
	// free bitmap
	// ------------------------------------------------------------------------

	always_comb begin
		low_idx = '0;
		for (int i = CELLS_PER_PORT - 1; i >= 0; i--)
			if (free_map[i])
				low_idx = LW'(i);   // last hit wins, so lowest index
	end

	assign free_cnt  = FW'($countones(free_map));
	assign hdr_ok    = (i_pkt_len != '0) && (free_cnt >= FW'(i_pkt_len)) && (|i_dest_mask);
	assign alloc     = i_slot && i_valid &&
		((state == ST_IDLE && i_header && hdr_ok) || state == ST_ACCEPT);
	assign alloc_vec = alloc ? (CELLS_PER_PORT'(1) << low_idx) : '0;

	// frees arrive any cycle, allocation only on the slot edge
	always_ff @(posedge clk_320M) begin
		if (i_rst) begin
			free_map <= '1;
		end else begin
			free_map <= (free_map | i_free) & ~alloc_vec;
		end
	end

	// ------------------------------------------------------------------------
	// packet FSM
	// ------------------------------------------------------------------------

	always_ff @(posedge clk_320M) begin
		if (i_rst) begin
			state <= ST_IDLE;
			rem   <= '0;
			o_wr  <= 1'b0;
		end else if (i_slot) begin
			o_wr <= alloc;   // request held for the whole slot
			if (i_valid) begin
				case (state)
					ST_IDLE: begin
						if (i_header) begin
							rem <= i_pkt_len - 1'b1;
							if (i_pkt_len > LEN_W'(1))   // single cell packets finish here
								state <= hdr_ok ? ST_ACCEPT : ST_DROP;
						end
					end
					ST_ACCEPT, ST_DROP: begin
						rem <= rem - 1'b1;
						if (rem == LEN_W'(1))
							state <= ST_IDLE;
					end
					default: state <= ST_IDLE;
				endcase
			end
		end
	end

	// address and mask of the request
	always_ff @(posedge clk_320M) begin
		if (alloc)
			o_addr <= BASE + AW'(low_idx);
		if (i_slot && i_valid && i_header && state == ST_IDLE)
			o_mask <= i_dest_mask;   // kept for the body cells
	end

	// space is reserved at the header so an accepted packet always finds a cell
	assert property (@(posedge clk_320M) disable iff (i_rst) alloc |-> |free_map);

	assert property (@(posedge clk_320M) disable iff (i_rst)
		(i_slot && i_valid && state == ST_IDLE) |-> i_header);

endmodule

`default_nettype wire

//--- hw/cell_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module cell_buffer #(
	parameter int CELLS_PER_PORT = 8,
	localparam int AW     = $clog2(gsm_pkg::N_PORTS * CELLS_PER_PORT),
	localparam int NCELLS = gsm_pkg::N_PORTS * CELLS_PER_PORT
) (
	input  wire                         clk_320M,
	input  wire                         i_rst,
	input  wire                         i_common_wr,
	input  wire [AW-1:0]                i_common_addr,
	input  wire gsm_pkg::port_mask_t    i_common_mask,
	input  wire gsm_pkg::cell_t         i_common_data,
	input  wire gsm_pkg::port_mask_t    i_rd,              // egress pops
	input  wire [AW-1:0]                i_rd_addr [gsm_pkg::N_PORTS],
	output gsm_pkg::cell_t              o_rd_data [gsm_pkg::N_PORTS],
	output gsm_pkg::port_mask_t         o_push,            // to the egress queues
	output logic [AW-1:0]               o_push_addr,
	output logic [NCELLS-1:0]           o_free_mask        // back to the mallocs
);
	import gsm_pkg::*;

	localparam int CW = $clog2(N_PORTS + 1);   // count up to all egress links

	cell_t          mem    [NCELLS];
	logic [CW-1:0]  refcnt [NCELLS];   // egress reads still owed per cell
	logic [CW-1:0]  dec    [NCELLS];   // reads landing on each cell this cycle

	// ------------------------------------------------------------------------
	// cell memory
	// ------------------------------------------------------------------------

	always_ff @(posedge clk_320M) begin
		if (i_common_wr)
			mem[i_common_addr] <= i_common_data;
	end

	// one asynchronous read port per egress link
	always_comb begin
		for (int q = 0; q < N_PORTS; q++)
			o_rd_data[q] = mem[i_rd_addr[q]];
	end

	always_ff @(posedge clk_320M) begin
		if (i_rst) begin
			o_push <= '0;
		end else begin
			o_push <= i_common_wr ? i_common_mask : '0;
		end
	end

	always_ff @(posedge clk_320M) begin
		o_push_addr <= i_common_addr;   // qualified by o_push
	end

	// ------------------------------------------------------------------------
	// reference counts
	// ------------------------------------------------------------------------

	// several egress links may pop the same multicast cell together
	always_comb begin
		for (int c = 0; c < NCELLS; c++) begin
			dec[c] = '0;
			for (int q = 0; q < N_PORTS; q++)
				if (i_rd[q] && i_rd_addr[q] == AW'(c))
					dec[c] = dec[c] + 1'b1;
		end
	end

	always_ff @(posedge clk_320M) begin
		if (i_rst) begin
			for (int c = 0; c < NCELLS; c++)
				refcnt[c] <= '0;
			o_free_mask <= '0;
		end else begin
			for (int c = 0; c < NCELLS; c++) begin
				if (i_common_wr && i_common_addr == AW'(c))
					refcnt[c] <= CW'($countones(i_common_mask));   // one per destination
				else
					refcnt[c] <= refcnt[c] - dec[c];
				o_free_mask[c] <= (dec[c] != '0) && (dec[c] == refcnt[c]);   // last reader
			end
		end
	end

	// egress queues only ever hold addresses of live cells
	for (genvar q = 0; q < N_PORTS; q++) begin : rd_chk_gen
		assert property (@(posedge clk_320M) disable iff (i_rst)
			i_rd[q] |-> refcnt[i_rd_addr[q]] != '0);
	end

endmodule

`default_nettype wire

//--- hw/egress_queue.sv
`timescale 1ns/10ps
`default_nettype none

module egress_queue #(
	parameter int CELLS_PER_PORT = 8,
	localparam int AW = $clog2(gsm_pkg::N_PORTS * CELLS_PER_PORT)
) (
	input  wire                     clk_320M,
	input  wire                     i_rst,
	input  wire                     i_push,        // new cell for this egress
	input  wire [AW-1:0]            i_push_addr,
	input  wire                     i_rd,          // egress link takes the head cell
	input  wire gsm_pkg::cell_t     i_rd_data,     // buffer data at o_rd_addr
	output logic                    o_valid,
	output gsm_pkg::cell_t          o_data,
	output logic                    o_rd,          // pop pulse to the buffer
	output logic [AW-1:0]           o_rd_addr
);
	import gsm_pkg::*;

	// room for every cell in the tile
	localparam int DEPTH = N_PORTS * CELLS_PER_PORT;

	logic [AW-1:0]  fifo [DEPTH];   // cell addresses in arrival order
	logic [AW-1:0]  wr_ptr;
	logic [AW-1:0]  rd_ptr;
	logic [AW:0]    count;

	// ------------------------------------------------------------------------
	// head presentation
	// ------------------------------------------------------------------------

	assign o_valid   = (count != '0);
	assign o_rd_addr = fifo[rd_ptr];          // fall through, no read latency
	assign o_data    = i_rd_data;             // cell held until popped
	assign o_rd      = i_rd && o_valid;       // a read on empty is ignored

	// ------------------------------------------------------------------------
	// address FIFO
	// ------------------------------------------------------------------------

	always_ff @(posedge clk_320M) begin
		if (i_push)
			fifo[wr_ptr] <= i_push_addr;
	end

	// depth is a power of two so the pointers wrap on their own
	always_ff @(posedge clk_320M) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (i_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (o_rd)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (AW+1)'(i_push) - (AW+1)'(o_rd);
		end
	end

	// each live cell is queued at most once per egress
	assert property (@(posedge clk_320M) disable iff (i_rst)
		i_push |-> (count != (AW+1)'(DEPTH)) || o_rd);

endmodule

`default_nettype wire

//--- hw/gsm_tile.sv
`timescale 1ns/10ps
`default_nettype none

module gsm_tile #(
	parameter int CELLS_PER_PORT = 8   // buffer cells owned by each ingress link
) (
	input  wire                              clk_320M,
	input  wire                              i_rst,

	// ingress links, sampled on the slot strobe
	input  wire gsm_pkg::port_mask_t         i_ingress_valid,
	input  wire gsm_pkg::port_mask_t         i_ingress_header,
	input  wire gsm_pkg::cell_t              i_ingress_data [gsm_pkg::N_PORTS],

	// egress links
	input  wire gsm_pkg::port_mask_t         i_egress_rd,
	output wire                              o_cell_slot,
	output wire gsm_pkg::port_mask_t         o_egress_valid,
	output wire gsm_pkg::cell_t              o_egress_data [gsm_pkg::N_PORTS]
);
	import gsm_pkg::*;

	localparam int AW     = $clog2(N_PORTS * CELLS_PER_PORT);  // tile wide cell address
	localparam int NCELLS = N_PORTS * CELLS_PER_PORT;

	// malloc write requests, held for a whole slot
	wire port_mask_t        req_wr;
	wire [AW-1:0]           req_addr [N_PORTS];
	wire port_mask_t        req_mask [N_PORTS];

	// common write bus, one ingress port per cycle
	wire                    common_wr;
	wire [AW-1:0]           common_addr;
	wire port_mask_t        common_mask;
	wire cell_t             common_data;

	wire port_mask_t        rd;                  // egress pops
	wire [AW-1:0]           rd_addr [N_PORTS];   // head address of each egress queue
	wire cell_t             rd_data [N_PORTS];
	wire port_mask_t        push;                // address pushes into the egress queues
	wire [AW-1:0]           push_addr;
	wire [NCELLS-1:0]       free_mask;           // one pulse per freed cell

	cell_slot_mux #(
		.AW(AW)
	) cell_slot_mux_inst (
		.clk_320M(clk_320M),
		.i_rst(i_rst),
		.i_ingress_data(i_ingress_data),
		.i_req_wr(req_wr),
		.i_req_addr(req_addr),
		.i_req_mask(req_mask),
		.o_cell_slot(o_cell_slot),
		.o_common_wr(common_wr),
		.o_common_addr(common_addr),
		.o_common_mask(common_mask),
		.o_common_data(common_data)
	);

	// one malloc per ingress link, each sees only its own block of free pulses
	for (genvar p = 0; p < N_PORTS; p++) begin : malloc_gen
		hw_malloc #(
			.CELLS_PER_PORT(CELLS_PER_PORT),
			.PORT_IDX(p)
		) hw_malloc_inst (
			.clk_320M(clk_320M),
			.i_rst(i_rst),
			.i_slot(o_cell_slot),
			.i_valid(i_ingress_valid[p]),
			.i_header(i_ingress_header[p]),
			.i_pkt_len(i_ingress_data[p][LEN_LOC +: LEN_W]),
			.i_dest_mask(i_ingress_data[p][DEST_LOC +: N_PORTS]),
			.i_free(free_mask[p*CELLS_PER_PORT +: CELLS_PER_PORT]),
			.o_wr(req_wr[p]),
			.o_addr(req_addr[p]),
			.o_mask(req_mask[p])
		);
	end

	cell_buffer #(
		.CELLS_PER_PORT(CELLS_PER_PORT)
	) cell_buffer_inst (
		.clk_320M(clk_320M),
		.i_rst(i_rst),
		.i_common_wr(common_wr),
		.i_common_addr(common_addr),
		.i_common_mask(common_mask),
		.i_common_data(common_data),
		.i_rd(rd),
		.i_rd_addr(rd_addr),
		.o_rd_data(rd_data),
		.o_push(push),
		.o_push_addr(push_addr),
		.o_free_mask(free_mask)
	);

	for (genvar q = 0; q < N_PORTS; q++) begin : egress_gen
		egress_queue #(
			.CELLS_PER_PORT(CELLS_PER_PORT)
		) egress_queue_inst (
			.clk_320M(clk_320M),
			.i_rst(i_rst),
			.i_push(push[q]),
			.i_push_addr(push_addr),
			.i_rd(i_egress_rd[q]),
			.i_rd_data(rd_data[q]),
			.o_valid(o_egress_valid[q]),
			.o_data(o_egress_data[q]),
			.o_rd(rd[q]),
			.o_rd_addr(rd_addr[q])
		);
	end

endmodule

`default_nettype wire

//--- bench/gsm_checker.sv
`timescale 1ns/10ps
`default_nettype none

module gsm_checker #(
	parameter int CELLS_PER_PORT = 8
) (
	input  wire                         clk_320M,
	input  wire                         i_rst,
	input  wire                         i_cell_slot,
	input  wire gsm_pkg::port_mask_t    i_ingress_valid,
	input  wire gsm_pkg::port_mask_t    i_ingress_header,
	input  wire gsm_pkg::cell_t         i_ingress_data [gsm_pkg::N_PORTS],
	input  wire gsm_pkg::port_mask_t    i_egress_rd,
	input  wire gsm_pkg::port_mask_t    i_egress_valid,
	input  wire gsm_pkg::cell_t         i_egress_data [gsm_pkg::N_PORTS],
	input  wire [3:0]                   i_test,       // test number of the slot on the links
	output int                          o_errors,
	output int                          o_pops,
	output int                          o_pending     // expected cells not yet popped
);
	import gsm_pkg::*;

	localparam int MAXC = 256;   // cell ids wrap here

	cell_t       exp_data  [N_PORTS][$];   // expected cells per egress, oldest first
	int          exp_id    [N_PORTS][$];
	int          exp_test  [N_PORTS][$];
	int          ref_left  [MAXC];         // egress reads still owed per cell
	int          owner     [MAXC];         // ingress port whose block holds the cell
	int          free_cnt  [N_PORTS];      // model of each malloc's free count
	int          late_free [N_PORTS];      // frees that reach the malloc on the next edge
	int          rem       [N_PORTS];      // body cells still to come
	logic        accepted  [N_PORTS];
	port_mask_t  pkt_mask  [N_PORTS];
	port_mask_t  held;                     // valid and not read last cycle
	cell_t       held_data [N_PORTS];
	int          slot_phase;               // cycles since reset release, modulo the slot
	int          next_id;
	int          errors;
	int          pops;
	int          pending;

	function automatic string test_name(input logic [3:0] t);
		case (t)
			4'd1: return "unicast";
			4'd2: return "multicast";
			4'd3: return "port_order";
			4'd4: return "exhaust_drop";
			4'd5: return "zero_mask";
			4'd6: return "hold_head";
			default: return "drain";
		endcase
	endfunction

	// one stored cell, queued on every egress of its packet mask
	task automatic store_cell(input int p, input cell_t c);
		int id;
		id = next_id % MAXC;
		next_id++;
		ref_left[id] = $countones(pkt_mask[p]);   // one read per destination
		owner[id]    = p;
		free_cnt[p]--;
		for (int q = 0; q < N_PORTS; q++) begin
			if (pkt_mask[p][q]) begin
				exp_data[q].push_back(c);
				exp_id[q].push_back(id);
				exp_test[q].push_back(int'(i_test));
				pending++;
			end
		end
	endtask

	// ports in order 0 to 3, which is also the order on the write bus
	task automatic take_slot();
		int len;
		for (int p = 0; p < N_PORTS; p++) begin
			if (i_ingress_valid[p] && rem[p] == 0 && i_ingress_header[p]) begin
				len         = int'(i_ingress_data[p][LEN_LOC +: LEN_W]);
				pkt_mask[p] = i_ingress_data[p][DEST_LOC +: N_PORTS];
				accepted[p] = (len != 0) && (free_cnt[p] >= len) && (pkt_mask[p] != '0);
				rem[p]      = (len == 0) ? 0 : len - 1;
				if (accepted[p])
					store_cell(p, i_ingress_data[p]);
			end else if (i_ingress_valid[p] && rem[p] != 0) begin
				rem[p]--;   // body cell follows its header's decision
				if (accepted[p])
					store_cell(p, i_ingress_data[p]);
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// edge by edge model and compare
	// ------------------------------------------------------------------------

	always @(posedge clk_320M) begin : watch
		int id;
		int t;
		cell_t exp;
		if (i_rst) begin
			for (int p = 0; p < N_PORTS; p++) begin
				free_cnt[p]  = CELLS_PER_PORT;
				late_free[p] = 0;
				rem[p]       = 0;
				accepted[p]  = 1'b0;
				exp_data[p].delete();
				exp_id[p].delete();
				exp_test[p].delete();
			end
			held       = '0;
			slot_phase = 0;
			next_id    = 0;
			errors     = 0;
			pops       = 0;
			pending    = 0;
		end else begin
			// strobe one cycle after reset release, then once per slot
			if (i_cell_slot !== (slot_phase == 1)) begin
				$display("CHECK FAILED %s slot strobe: expected %b, actual %b",
					test_name(i_test), slot_phase == 1, i_cell_slot);
				errors++;
			end
			slot_phase = (slot_phase + 1) % N_PORTS;
			if (i_cell_slot)
				take_slot();   // admission sees frees of two edges back
			for (int p = 0; p < N_PORTS; p++) begin
				free_cnt[p]  += late_free[p];
				late_free[p] = 0;
			end
			for (int q = 0; q < N_PORTS; q++) begin
				// an unread head stays put
				if (held[q] && (!i_egress_valid[q] || i_egress_data[q] !== held_data[q])) begin
					$display("CHECK FAILED %s egress %0d head: expected %h, actual %h",
						test_name(i_test), q, held_data[q], i_egress_data[q]);
					errors++;
				end
				if (i_egress_rd[q] && i_egress_valid[q]) begin
					pops++;
					if (exp_data[q].size() == 0) begin
						$display("egress %0d delivered a cell that no accepted packet holds", q);
						errors++;
					end else begin
						exp = exp_data[q].pop_front();
						id  = exp_id[q].pop_front();
						t   = exp_test[q].pop_front();
						pending--;
						if (i_egress_data[q] !== exp) begin
							$display("CHECK FAILED %s egress %0d: expected %h, actual %h",
								test_name(4'(t)), q, exp, i_egress_data[q]);
							errors++;
						end
						ref_left[id]--;
						if (ref_left[id] == 0)
							late_free[owner[id]]++;   // last reader frees the cell
					end
				end
				held[q]      = i_egress_valid[q] && !i_egress_rd[q];
				held_data[q] = i_egress_data[q];
			end
		end
		o_errors  <= errors;
		o_pops    <= pops;
		o_pending <= pending;
	end

endmodule

`default_nettype wire

//--- bench/tb_gsm_tile.sv
`timescale 1ns/10ps
`default_nettype none

module tb_gsm_tile;
	import gsm_pkg::*;

	localparam int CELLS_PER_PORT = 8;
	localparam int NT    = 29;                  // slots in the table
	localparam int LIMIT = 5 + NT * 4 + 64;     // reset, one slot per row, drain margin
	localparam logic [31:0] SEED = 32'h571ae1f9;

	// row fields {test, egress rd, valid, header, len per port, mask per port, tag}
	// port p sits at len[3p+:3] and mask[4p+:4], port 3 leftmost
	typedef logic [51:0] row_t;

	localparam row_t TABLE [NT] = '{
		{4'd1, 4'hf, 4'hf, 4'hf, 12'o1111, 16'h8421, 8'h01},   // each port to its own egress
		{4'd1, 4'hf, 4'hf, 4'hf, 12'o1111, 16'h1248, 8'h02},   // crossed
		{4'd2, 4'hf, 4'h5, 4'h5, 12'o0201, 16'h0f0f, 8'h03},   // broadcast from ports 0 and 2
		{4'd2, 4'h7, 4'h4, 4'h0, 12'o0000, 16'h0000, 8'h04},   // egress 3 keeps the broadcast cells
		{4'd3, 4'h7, 4'hf, 4'hf, 12'o3333, 16'h4444, 8'h05},   // all ports onto egress 2
		{4'd3, 4'h7, 4'hf, 4'h0, 12'o0000, 16'h0000, 8'h06},
		{4'd3, 4'hf, 4'hf, 4'h0, 12'o0000, 16'h0000, 8'h07},
		{4'd5, 4'hf, 4'h9, 4'h9, 12'o3001, 16'h0002, 8'h08},   // port 3 has no destination
		{4'd5, 4'hf, 4'h8, 4'h0, 12'o0000, 16'h0000, 8'h09},
		{4'd5, 4'hf, 4'h8, 4'h0, 12'o0000, 16'h0000, 8'h0a},
		{4'd0, 4'hf, 4'h0, 4'h0, 12'o0000, 16'h0000, 8'h0b},
		{4'd4, 4'h0, 4'h2, 4'h2, 12'o0070, 16'h0020, 8'h0c},   // seven cells, reads stopped
		{4'd4, 4'h0, 4'h2, 4'h0, 12'o0000, 16'h0000, 8'h0d},
		{4'd4, 4'h0, 4'h2, 4'h0, 12'o0000, 16'h0000, 8'h0e},
		{4'd4, 4'h0, 4'h2, 4'h0, 12'o0000, 16'h0000, 8'h0f},
		{4'd4, 4'h0, 4'h2, 4'h0, 12'o0000, 16'h0000, 8'h10},
		{4'd4, 4'h0, 4'h2, 4'h0, 12'o0000, 16'h0000, 8'h11},
		{4'd4, 4'h0, 4'h2, 4'h0, 12'o0000, 16'h0000, 8'h12},
		{4'd4, 4'h0, 4'h2, 4'h2, 12'o0010, 16'h0020, 8'h13},   // last free cell of port 1
		{4'd4, 4'h0, 4'h2, 4'h2, 12'o0020, 16'h0020, 8'h14},   // no room, whole packet goes
		{4'd4, 4'h0, 4'h2, 4'h0, 12'o0000, 16'h0000, 8'h15},
		{4'd4, 4'hf, 4'h0, 4'h0, 12'o0000, 16'h0000, 8'h16},   // reads back on
		{4'd4, 4'hf, 4'h0, 4'h0, 12'o0000, 16'h0000, 8'h17},
		{4'd4, 4'hf, 4'h0, 4'h0, 12'o0000, 16'h0000, 8'h18},
		{4'd4, 4'hf, 4'h2, 4'h2, 12'o0010, 16'h0020, 8'h19},   // fits again
		{4'd6, 4'he, 4'h8, 4'h8, 12'o1000, 16'h1000, 8'h1a},   // egress 0 not read
		{4'd6, 4'he, 4'h0, 4'h0, 12'o0000, 16'h0000, 8'h1b},
		{4'd6, 4'he, 4'h0, 4'h0, 12'o0000, 16'h0000, 8'h1c},
		{4'd6, 4'hf, 4'h0, 4'h0, 12'o0000, 16'h0000, 8'h1d}
	};

	logic        clk_320M = 1'b0;
	logic        rst;
	port_mask_t  ingress_valid;
	port_mask_t  ingress_header;
	port_mask_t  egress_rd;
	cell_t       ingress_data [N_PORTS];
	logic        cell_slot;
	port_mask_t  egress_valid;
	cell_t       egress_data [N_PORTS];
	logic [3:0]  test_idx;
	logic [31:0] lfsr;
	int          errors;
	int          pops;
	int          pending;
	int          cycles = 0;

	always #20 clk_320M = ~clk_320M;   // 25 MHz stand in for the 320 MHz clock

	gsm_tile #(
		.CELLS_PER_PORT(CELLS_PER_PORT)
	) dut_i (
		.clk_320M(clk_320M),
		.i_rst(rst),
		.i_ingress_valid(ingress_valid),
		.i_ingress_header(ingress_header),
		.i_ingress_data(ingress_data),
		.i_egress_rd(egress_rd),
		.o_cell_slot(cell_slot),
		.o_egress_valid(egress_valid),
		.o_egress_data(egress_data)
	);

	gsm_checker #(
		.CELLS_PER_PORT(CELLS_PER_PORT)
	) checker_i (
		.clk_320M(clk_320M),
		.i_rst(rst),
		.i_cell_slot(cell_slot),
		.i_ingress_valid(ingress_valid),
		.i_ingress_header(ingress_header),
		.i_ingress_data(ingress_data),
		.i_egress_rd(egress_rd),
		.i_egress_valid(egress_valid),
		.i_egress_data(egress_data),
		.i_test(test_idx),
		.o_errors(errors),
		.o_pops(pops),
		.o_pending(pending)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// random payload, then header fields and a port and slot tag on top
	function automatic cell_t make_cell(input int p, input row_t r);
		cell_t c;
		for (int b = 0; b < DWIDTH; b++) begin
			lfsr = lfsr_step(lfsr);   // one step per bit
			c[b] = lfsr[0];
		end
		c[LEN_LOC +: LEN_W]    = r[24 + 3*p +: 3];
		c[DEST_LOC +: N_PORTS] = r[8 + 4*p +: 4];
		c[15:0]                = {8'(p), r[7:0]};
		return c;
	endfunction

	initial begin
		rst            = 1'b1;
		ingress_valid  = '0;
		ingress_header = '0;
		egress_rd      = '0;
		test_idx       = '0;
		lfsr           = SEED;
		for (int p = 0; p < N_PORTS; p++)
			ingress_data[p] = '0;
		repeat (5) @(posedge clk_320M);
		rst <= 1'b0;   // first slot strobe follows in the next cycle
		for (int i = 0; i < NT; i++) begin
			for (int p = 0; p < N_PORTS; p++)
				ingress_data[p] <= make_cell(p, TABLE[i]);
			ingress_valid  <= TABLE[i][43:40];
			ingress_header <= TABLE[i][39:36];
			egress_rd      <= TABLE[i][47:44];
			test_idx       <= TABLE[i][51:48];
			do @(posedge clk_320M); while (!cell_slot);   // row sampled on this edge
		end
		ingress_valid  <= '0;
		ingress_header <= '0;
		egress_rd      <= '1;
		test_idx       <= '0;
		do @(posedge clk_320M); while (pending != 0 || egress_valid != '0);
		$display("run done: %0d egress pops checked, %0d errors", pops, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// ------------------------------------------------------------------------
	// run limit
	// ------------------------------------------------------------------------

	always @(posedge clk_320M) begin
		cycles <= cycles + 1;
		if (cycles == LIMIT) begin
			$display("timeout: egress queues still busy after %0d cycles", cycles);
			$display("run stopped: %0d egress pops checked, %0d errors", pops, errors);
			$display("STATUS: FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- filelist.f
hw/gsm_pkg.sv
hw/cell_slot_mux.sv
hw/hw_malloc.sv
hw/cell_buffer.sv
hw/egress_queue.sv
hw/gsm_tile.sv
bench/gsm_checker.sv
bench/tb_gsm_tile.sv

//--- Makefile
TOP = tb_gsm_tile

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf obj_dir
